// File: include/cpu_params.svh
/* core sizes and constants */

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and address width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ID_W 5

// instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// data memory size in bytes
`define DMEM_BYTES 1024

// first fetch address after reset
`define PC_RESET 32'h0000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

// File: verilog/cpuPkg.sv
/* core enum types */

package cpuPkg;

  // alu operation, branch compares return 1 when taken
  typedef enum logic [4:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluCopyB,
    aluBeq,
    aluBne,
    aluBlt,
    aluBge,
    aluBltu,
    aluBgeu
  } aluOpE;

  // load and store access size
  typedef enum logic [1:0] {
    memByte,
    memHalf,
    memWord
  } memWidthE;

  // run control states
  typedef enum logic [1:0] {
    stIdle,
    stRun,
    stHalt,
    stTrap
  } runStateE;

endpackage

// File: verilog/instMem.sv
/* instruction memory */

`timescale 1ns/100ps
`include "cpu_params.svh"

module instMem (
  input  logic                            clk,
  input  logic                            we,
  input  logic [$clog2(`IMEM_WORDS)-1:0]  waddr,
  input  logic [31:0]                     wdata,
  input  logic [`XLEN-1:0]                pc,
  output logic [31:0]                     inst
);

  localparam int AW = $clog2(`IMEM_WORDS);

  logic [31:0] mem [`IMEM_WORDS];

  // loaded by the testbench while the core is idle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // word index from the byte pc
  assign inst = mem[pc[AW+1:2]];

endmodule

// File: verilog/decoder.sv
/* RV32I instruction decoder */

`timescale 1ns/100ps
`include "cpu_params.svh"

module decoder import cpuPkg::*; (
  input  logic [31:0]           inst,
  output logic [`REG_ID_W-1:0]  rd,
  output logic [`REG_ID_W-1:0]  rs1,
  output logic [`REG_ID_W-1:0]  rs2,
  output logic [`XLEN-1:0]      imm,
  output aluOpE                 aluOp,
  output memWidthE              width,
  output logic                  regWe,
  output logic                  memWe,
  output logic                  isLoad,
  output logic                  isUnsigned,
  output logic                  useImm,
  output logic                  usePc,
  output logic                  isBranch,
  output logic                  isJal,
  output logic                  isJalr,
  output logic                  isEbreak,
  output logic                  isIllegal
);

  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [31:0] ebreakInst = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`XLEN-1:0] immI;
  logic [`XLEN-1:0] immS;
  logic [`XLEN-1:0] immB;
  logic [`XLEN-1:0] immU;
  logic [`XLEN-1:0] immJ;
  logic regWeRaw;
  logic memWeRaw;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm = immI;
    aluOp = aluAdd;
    width = memWord;
    regWeRaw = 1'b0;
    memWeRaw = 1'b0;
    isLoad = 1'b0;
    isUnsigned = 1'b0;
    useImm = 1'b0;
    usePc = 1'b0;
    isBranch = 1'b0;
    isJal = 1'b0;
    isJalr = 1'b0;
    isEbreak = 1'b0;
    isIllegal = 1'b0;
    case (opcode)
      opLui: begin
        imm = immU;
        aluOp = aluCopyB;
        useImm = 1'b1;
        regWeRaw = 1'b1;
      end
      opAuipc: begin
        imm = immU;
        usePc = 1'b1;
        useImm = 1'b1;
        regWeRaw = 1'b1;
      end
      opJal: begin
        // target pc + imm comes out of the alu
        imm = immJ;
        usePc = 1'b1;
        useImm = 1'b1;
        regWeRaw = 1'b1;
        isJal = 1'b1;
      end
      opJalr: begin
        useImm = 1'b1;
        regWeRaw = 1'b1;
        isJalr = funct3 == 3'b000;
        isIllegal = funct3 != 3'b000;
      end
      opBranch: begin
        imm = immB;
        isBranch = 1'b1;
        case (funct3)
          3'b000: aluOp = aluBeq;
          3'b001: aluOp = aluBne;
          3'b100: aluOp = aluBlt;
          3'b101: aluOp = aluBge;
          3'b110: aluOp = aluBltu;
          3'b111: aluOp = aluBgeu;
          default: begin
            isBranch = 1'b0;
            isIllegal = 1'b1;
          end
        endcase
      end
      opLoad: begin
        useImm = 1'b1;
        regWeRaw = 1'b1;
        isUnsigned = funct3[2];
        width = memWidthE'(funct3[1:0]);
        // lb lh lw lbu lhu only
        isIllegal = funct3[1:0] == 2'b11 || funct3 == 3'b110;
        isLoad = !isIllegal;
      end
      opStore: begin
        imm = immS;
        useImm = 1'b1;
        memWeRaw = 1'b1;
        width = memWidthE'(funct3[1:0]);
        isIllegal = funct3[2] || funct3[1:0] == 2'b11;
      end
      opImm: begin
        useImm = 1'b1;
        regWeRaw = 1'b1;
        case (funct3)
          3'b000: aluOp = aluAdd;
          3'b010: aluOp = aluSlt;
          3'b011: aluOp = aluSltu;
          3'b100: aluOp = aluXor;
          3'b110: aluOp = aluOr;
          3'b111: aluOp = aluAnd;
          3'b001: begin
            aluOp = aluSll;
            isIllegal = funct7 != 7'b0000000;
          end
          default: begin
            // srli or srai by bit 30
            aluOp = inst[30] ? aluSra : aluSrl;
            isIllegal = {funct7[6], funct7[4:0]} != 6'b0;
          end
        endcase
      end
      opReg: begin
        regWeRaw = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: aluOp = aluAdd;
          10'b0100000_000: aluOp = aluSub;
          10'b0000000_001: aluOp = aluSll;
          10'b0000000_010: aluOp = aluSlt;
          10'b0000000_011: aluOp = aluSltu;
          10'b0000000_100: aluOp = aluXor;
          10'b0000000_101: aluOp = aluSrl;
          10'b0100000_101: aluOp = aluSra;
          10'b0000000_110: aluOp = aluOr;
          10'b0000000_111: aluOp = aluAnd;
          default: isIllegal = 1'b1;
        endcase
      end
      default: begin
        // system space holds only ebreak here
        isEbreak = inst == ebreakInst;
        isIllegal = inst != ebreakInst;
      end
    endcase
  end

  assign regWe = regWeRaw && !isIllegal;
  assign memWe = memWeRaw && !isIllegal;

endmodule

// File: verilog/regFile.sv
/* integer register file */

`timescale 1ns/100ps
`include "cpu_params.svh"

module regFile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  logic [`REG_ID_W-1:0]  waddr,
  input  logic [`XLEN-1:0]      wdata,
  input  logic [`REG_ID_W-1:0]  raddr1,
  input  logic [`REG_ID_W-1:0]  raddr2,
  input  logic [`REG_ID_W-1:0]  dbgAddr,
  output logic [`XLEN-1:0]      rdata1,
  output logic [`XLEN-1:0]      rdata2,
  output logic [`XLEN-1:0]      dbgData
);

  // x0 is cleared by reset and never written
  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];
  assign dbgData = regs[dbgAddr];

  // a write to x0 must never show up on a read of x0
  assert property (@(posedge clk) disable iff (rst)
    (raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0));

endmodule

// File: verilog/alu.sv
/* execute stage ALU */

`timescale 1ns/100ps
`include "cpu_params.svh"

module alu import cpuPkg::*; (
  input  logic [`XLEN-1:0]  a,
  input  logic [`XLEN-1:0]  b,
  input  aluOpE             op,
  output logic [`XLEN-1:0]  result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluSll:   result = a << shamt;
      aluSlt:   result = `XLEN'($signed(a) < $signed(b));
      aluSltu:  result = `XLEN'(a < b);
      aluXor:   result = a ^ b;
      aluSrl:   result = a >> shamt;
      aluSra:   result = $signed(a) >>> shamt;
      aluOr:    result = a | b;
      aluAnd:   result = a & b;
      aluCopyB: result = b;
      // compares give the taken flag in bit 0
      aluBeq:   result = `XLEN'(a == b);
      aluBne:   result = `XLEN'(a != b);
      aluBlt:   result = `XLEN'($signed(a) < $signed(b));
      aluBge:   result = `XLEN'($signed(a) >= $signed(b));
      aluBltu:  result = `XLEN'(a < b);
      aluBgeu:  result = `XLEN'(a >= b);
      default:  result = '0;
    endcase
  end

endmodule

// File: verilog/dataMem.sv
/* byte-addressed data memory */

`timescale 1ns/100ps
`include "cpu_params.svh"

module dataMem import cpuPkg::*; (
  input  logic              clk,
  input  logic [`XLEN-1:0]  addr,
  input  logic [`XLEN-1:0]  wdata,
  input  logic              we,
  input  logic              re,
  input  memWidthE          width,
  input  logic              isUnsigned,
  output logic [`XLEN-1:0]  rdata
);

  localparam int AW = $clog2(`DMEM_BYTES);

  logic [7:0] mem [`DMEM_BYTES];
  logic [AW-1:0] a0;
  logic [AW-1:0] a1;
  logic [AW-1:0] a2;
  logic [AW-1:0] a3;
  logic [31:0] word;

  assign a0 = addr[AW-1:0];
  assign a1 = a0 + AW'(1);
  assign a2 = a0 + AW'(2);
  assign a3 = a0 + AW'(3);

  // little-endian, only the addressed bytes change
  always_ff @(posedge clk) begin
    if (we) begin
      mem[a0] <= wdata[7:0];
      if (width != memByte) begin
        mem[a1] <= wdata[15:8];
      end
      if (width == memWord) begin
        mem[a2] <= wdata[23:16];
        mem[a3] <= wdata[31:24];
      end
    end
  end

  assign word = {mem[a3], mem[a2], mem[a1], mem[a0]};

  always_comb begin
    case (width)
      memByte: rdata = {{24{word[7] && !isUnsigned}}, word[7:0]};
      memHalf: rdata = {{16{word[15] && !isUnsigned}}, word[15:0]};
      default: rdata = word;
    endcase
  end

  // no misaligned access support
  assert property (@(posedge clk) (we || re) |->
    (width == memByte) ||
    (width == memHalf && !addr[0]) ||
    (width == memWord && addr[1:0] == 2'b00));

endmodule

// File: verilog/runControl.sv
/* run control FSM */

`timescale 1ns/100ps

module runControl import cpuPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  ebreakEx,
  input  logic  illegalEx,
  output logic  running,
  output logic  halted,
  output logic  trapped
);

  runStateE state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle: begin
          if (start) begin
            state <= stRun;
          end
        end
        stRun: begin
          if (illegalEx) begin
            state <= stTrap;
          end else if (ebreakEx) begin
            state <= stHalt;
          end
        end
        // halt and trap hold until reset
        default: state <= state;
      endcase
    end
  end

  assign running = state == stRun;
  assign halted = state == stHalt;
  assign trapped = state == stTrap;

  // a stop level holds until reset so halt and trap never meet
  assert property (@(posedge clk) disable iff (rst)
    (halted || trapped) |=> $stable({halted, trapped}));

  // execute reports stop events only from a running core
  assert property (@(posedge clk) disable iff (rst) (ebreakEx || illegalEx) |-> running);

endmodule

// File: verilog/perfCounter.sv
/* cycle and retired instruction counters */

`timescale 1ns/100ps
`include "cpu_params.svh"

module perfCounter (
  input  logic              clk,
  input  logic              rst,
  input  logic              running,
  input  logic              retire,
  output logic [`XLEN-1:0]  cycleCount,
  output logic [`XLEN-1:0]  instRet
);

  always_ff @(posedge clk) begin
    if (rst) begin
      cycleCount <= '0;
      instRet <= '0;
    end else begin
      if (running) begin
        cycleCount <= cycleCount + 1'b1;
      end
      if (retire) begin
        instRet <= instRet + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) retire |-> running);

endmodule

// File: verilog/cpu.sv
/* three-stage RV32I core */

`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu import cpuPkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic                            imemWe,
  input  logic [$clog2(`IMEM_WORDS)-1:0]  imemAddr,
  input  logic [31:0]                     imemWdata,
  input  logic [`REG_ID_W-1:0]            dbgAddr,
  output logic                            running,
  output logic                            halted,
  output logic                            trapped,
  output logic [`XLEN-1:0]                cycleCount,
  output logic [`XLEN-1:0]                instRet,
  output logic [`XLEN-1:0]                dbgData
);

  logic [`XLEN-1:0] pc;
  logic [31:0] fetchInst;
  logic idValid;
  logic [31:0] idInst;
  logic [`XLEN-1:0] idPc;
  logic [31:0] decInst;

  logic [`REG_ID_W-1:0] dRd;
  logic [`REG_ID_W-1:0] dRs1;
  logic [`REG_ID_W-1:0] dRs2;
  logic [`XLEN-1:0] dImm;
  aluOpE dAluOp;
  memWidthE dWidth;
  logic dRegWe;
  logic dMemWe;
  logic dIsLoad;
  logic dIsUnsigned;
  logic dUseImm;
  logic dUsePc;
  logic dIsBranch;
  logic dIsJal;
  logic dIsJalr;
  logic dIsEbreak;
  logic dIsIllegal;
  logic [`XLEN-1:0] rfData1;
  logic [`XLEN-1:0] rfData2;
  logic [`XLEN-1:0] fwdData1;
  logic [`XLEN-1:0] fwdData2;

  logic exValid;
  logic [`XLEN-1:0] exPc;
  logic [`XLEN-1:0] exImm;
  logic [`XLEN-1:0] exRs1Val;
  logic [`XLEN-1:0] exRs2Val;
  logic [`REG_ID_W-1:0] exRd;
  aluOpE exAluOp;
  memWidthE exWidth;
  logic exRegWe;
  logic exMemWe;
  logic exIsLoad;
  logic exIsUnsigned;
  logic exUseImm;
  logic exUsePc;
  logic exIsBranch;
  logic exIsJal;
  logic exIsJalr;
  logic exIsEbreak;
  logic exIsIllegal;

  logic exActive;
  logic exWrites;
  logic [`XLEN-1:0] aluA;
  logic [`XLEN-1:0] aluB;
  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] memRdata;
  logic [`XLEN-1:0] wbData;
  logic taken;
  logic flush;
  logic [`XLEN-1:0] target;

  // fetch
  instMem instMem_inst (
    .clk   (clk),
    .we    (imemWe && !running),
    .waddr (imemAddr),
    .wdata (imemWdata),
    .pc    (pc),
    .inst  (fetchInst)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `PC_RESET;
    end else if (running) begin
      pc <= flush ? target : pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      idValid <= 1'b0;
    end else if (running) begin
      idValid <= !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (running) begin
      idInst <= fetchInst;
      idPc <= pc;
    end
  end

  // decode, a bubble decodes as a nop
  assign decInst = idValid ? idInst : `NOP_INST;

  decoder decoder_inst (
    .inst       (decInst),
    .rd         (dRd),
    .rs1        (dRs1),
    .rs2        (dRs2),
    .imm        (dImm),
    .aluOp      (dAluOp),
    .width      (dWidth),
    .regWe      (dRegWe),
    .memWe      (dMemWe),
    .isLoad     (dIsLoad),
    .isUnsigned (dIsUnsigned),
    .useImm     (dUseImm),
    .usePc      (dUsePc),
    .isBranch   (dIsBranch),
    .isJal      (dIsJal),
    .isJalr     (dIsJalr),
    .isEbreak   (dIsEbreak),
    .isIllegal  (dIsIllegal)
  );

  regFile regFile_inst (
    .clk     (clk),
    .rst     (rst),
    .we      (exWrites),
    .waddr   (exRd),
    .wdata   (wbData),
    .raddr1  (dRs1),
    .raddr2  (dRs2),
    .dbgAddr (dbgAddr),
    .rdata1  (rfData1),
    .rdata2  (rfData2),
    .dbgData (dbgData)
  );

  // execute writes at this edge, so take its value directly
  assign fwdData1 = (exWrites && exRd != '0 && exRd == dRs1) ? wbData : rfData1;
  assign fwdData2 = (exWrites && exRd != '0 && exRd == dRs2) ? wbData : rfData2;

  always_ff @(posedge clk) begin
    if (rst) begin
      exValid <= 1'b0;
    end else if (running) begin
      exValid <= idValid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (running) begin
      exPc <= idPc;
      exImm <= dImm;
      exRs1Val <= fwdData1;
      exRs2Val <= fwdData2;
      exRd <= dRd;
      exAluOp <= dAluOp;
      exWidth <= dWidth;
      exRegWe <= dRegWe;
      exMemWe <= dMemWe;
      exIsLoad <= dIsLoad;
      exIsUnsigned <= dIsUnsigned;
      exUseImm <= dUseImm;
      exUsePc <= dUsePc;
      exIsBranch <= dIsBranch;
      exIsJal <= dIsJal;
      exIsJalr <= dIsJalr;
      exIsEbreak <= dIsEbreak;
      exIsIllegal <= dIsIllegal;
    end
  end

  // execute, nothing changes once the core stops
  assign exActive = exValid && running;
  assign exWrites = exActive && exRegWe;

  assign aluA = exUsePc ? exPc : exRs1Val;
  assign aluB = exUseImm ? exImm : exRs2Val;

  alu alu_inst (
    .a      (aluA),
    .b      (aluB),
    .op     (exAluOp),
    .result (aluResult)
  );

  dataMem dataMem_inst (
    .clk        (clk),
    .addr       (aluResult),
    .wdata      (exRs2Val),
    .we         (exActive && exMemWe),
    .re         (exActive && exIsLoad),
    .width      (exWidth),
    .isUnsigned (exIsUnsigned),
    .rdata      (memRdata)
  );

  always_comb begin
    if (exIsJal || exIsJalr) begin
      wbData = exPc + 32'd4;
    end else if (exIsLoad) begin
      wbData = memRdata;
    end else begin
      wbData = aluResult;
    end
  end

  // redirect, two bubbles behind it
  assign taken = exIsBranch && aluResult[0];
  assign flush = exActive && (taken || exIsJal || exIsJalr);
  assign target = exIsBranch ? exPc + exImm : {aluResult[`XLEN-1:1], 1'b0};

  runControl runControl_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .ebreakEx  (exActive && exIsEbreak),
    .illegalEx (exActive && exIsIllegal),
    .running   (running),
    .halted    (halted),
    .trapped   (trapped)
  );

  perfCounter perfCounter_inst (
    .clk        (clk),
    .rst        (rst),
    .running    (running),
    .retire     (exActive && !exIsEbreak && !exIsIllegal),
    .cycleCount (cycleCount),
    .instRet    (instRet)
  );

endmodule

// File: sim/cpuTb.sv
/* RV32I core testbench */

`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuTb;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] EBREAK = 32'h0010_0073;
  localparam int PREFIX = 14;

  logic clk;
  logic rst;
  logic start;
  logic imemWe;
  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr;
  logic [31:0] imemWdata;
  logic [`REG_ID_W-1:0] dbgAddr;
  logic running;
  logic halted;
  logic trapped;
  logic [`XLEN-1:0] cycleCount;
  logic [`XLEN-1:0] instRet;
  logic [`XLEN-1:0] dbgData;

  // generated program and the reference model state
  logic [31:0] prog [`IMEM_WORDS];
  int progLen;
  logic [31:0] mRegs [32];
  logic [7:0] mMem [`DMEM_BYTES];
  int mRetired;
  logic mHalted;
  logic mTrapped;
  int storeAddr [$];
  int storeWidth [$];

  cpu cpu_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .imemWe     (imemWe),
    .imemAddr   (imemAddr),
    .imemWdata  (imemWdata),
    .dbgAddr    (dbgAddr),
    .running    (running),
    .halted     (halted),
    .trapped    (trapped),
    .cycleCount (cycleCount),
    .instRet    (instRet),
    .dbgData    (dbgData)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic int rnd(input int n);
    return int'($urandom % n);
  endfunction

  // operands stay in x1..x7 and destinations may hit x0
  function automatic int srcReg();
    return 1 + rnd(7);
  endfunction

  function automatic int dstReg();
    return rnd(8);
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
      input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(input int imm, input int rs1, input logic [2:0] f3,
      input int rd, input logic [6:0] op);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1,
      input logic [2:0] f3);
    logic [11:0] i12;
    i12 = 12'(imm);
    return {i12[11:5], 5'(rs2), 5'(rs1), f3, i12[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(input int off, input int rs1, input int rs2,
      input logic [2:0] f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(input int off, input int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input int rd,
      input logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction

  // register and immediate ops, lui, auipc
  function automatic logic [31:0] genAlu();
    int kind;
    int f3;
    int imm;
    kind = rnd(6);
    f3 = rnd(8);
    if (kind < 2) begin
      return encR(((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 7'h20 : 7'h00,
        srcReg(), srcReg(), 3'(f3), dstReg());
    end else if (kind < 4) begin
      if (f3 == 1) begin
        imm = rnd(32);
      end else if (f3 == 5) begin
        imm = rnd(32) | (rnd(2) * 32'h400);
      end else begin
        imm = rnd(4096) - 2048;
      end
      return encI(imm, srcReg(), 3'(f3), dstReg(), 7'b0010011);
    end else begin
      return encU(20'($urandom), dstReg(), (kind == 4) ? 7'b0110111 : 7'b0010111);
    end
  endfunction

  // kind 0 alu, 1 memory, 2 control flow, 3 illegal encoding
  task automatic buildProgram(input int kind);
    int n;
    int i;
    int k;
    int w;
    int room;
    int badAt;
    int b;
    logic [31:0] bad [5];
    logic [2:0] brF3 [6];
    // slots that an earlier jump lands on
    logic isTarget [`IMEM_WORDS];
    bad = '{32'h0000_0073, 32'h0000_000f, 32'h3400_1073, 32'hffff_ffff, 32'h0220_80b3};
    brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (i = 0; i < `IMEM_WORDS; i++) begin
      prog[i] = `NOP_INST;
      isTarget[i] = 1'b0;
    end
    storeAddr.delete();
    storeWidth.delete();
    // give x1..x7 random starting values
    for (i = 1; i < 8; i++) begin
      prog[2 * i - 2] = encU(20'($urandom), i, 7'b0110111);
      prog[2 * i - 1] = encI(rnd(4096), i, 3'd0, i, 7'b0010011);
    end
    n = 20 + rnd(20);
    progLen = PREFIX + n + 1;
    badAt = PREFIX + rnd(n);
    i = PREFIX;
    while (i < progLen - 1) begin
      room = progLen - 1 - i;
      prog[i] = genAlu();
      if (kind == 1) begin
        k = rnd(3);
        if (k == 1 || (k == 2 && storeAddr.size() == 0)) begin
          w = rnd(3);
          storeAddr.push_back(rnd(256) & ~((1 << w) - 1));
          storeWidth.push_back(w);
          prog[i] = encS(storeAddr[$], srcReg(), 0, 3'(w));
        end else if (k == 2) begin
          k = rnd(storeAddr.size());
          w = rnd(storeWidth[k] + 1);
          if (w < 2 && rnd(2) == 1) begin
            w = w + 4;
          end
          prog[i] = encI(storeAddr[k], 0, 3'(w), dstReg(), 7'b0000011);
        end
      end else if (kind == 2) begin
        k = 1 + rnd(room < 5 ? room : 5);
        case (rnd(5))
          0: begin
            prog[i] = encB(4 * k, srcReg(), srcReg(), brF3[rnd(6)]);
            isTarget[i + k] = 1'b1;
          end
          1: begin
            prog[i] = encJ(4 * k, dstReg());
            isTarget[i + k] = 1'b1;
          end
          2: begin
            if (room >= 2 && !isTarget[i + 1]) begin
              // auipc then jalr relative to it when nothing jumps onto the jalr
              b = srcReg();
              k = 1 + rnd(room - 1 < 5 ? room - 1 : 5);
              prog[i] = encU(20'd0, b, 7'b0010111);
              i++;
              prog[i] = encI(4 * (1 + k), b, 3'd0, dstReg(), 7'b1100111);
              isTarget[i + k] = 1'b1;
            end
          end
          default: ;
        endcase
      end else if (kind == 3 && i == badAt) begin
        prog[i] = bad[rnd(5)];
      end
      i++;
    end
    prog[progLen - 1] = EBREAK;
  endtask

  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // little-endian load with sign or zero extension by funct3
  function automatic logic [31:0] loadModel(input logic [31:0] addr, input logic [2:0] f3);
    int p;
    logic [31:0] w;
    p = int'(addr[9:0]);
    w = {mMem[(p + 3) % 1024], mMem[(p + 2) % 1024], mMem[(p + 1) % 1024], mMem[p]};
    case (f3)
      3'd0: return {{24{w[7]}}, w[7:0]};
      3'd1: return {{16{w[15]}}, w[15:0]};
      3'd4: return {24'b0, w[7:0]};
      3'd5: return {16'b0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic storeModel(input logic [31:0] addr, input logic [2:0] f3,
      input logic [31:0] data);
    int p;
    p = int'(addr[9:0]);
    mMem[p] = data[7:0];
    if (f3 != 0) begin
      mMem[(p + 1) % 1024] = data[15:8];
    end
    if (f3 == 2) begin
      mMem[(p + 2) % 1024] = data[23:16];
      mMem[(p + 3) % 1024] = data[31:24];
    end
  endtask

  // sequential instruction-level execution of prog
  task automatic runModel();
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [2:0] f3;
    logic [6:0] f7;
    logic wr;
    logic illegal;
    logic cond;
    logic done;
    int steps;
    for (int r = 0; r < 32; r++) begin
      mRegs[r] = '0;
    end
    pc = '0;
    mRetired = 0;
    mHalted = 1'b0;
    mTrapped = 1'b0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
      inst = prog[pc[9:2]];
      f3 = inst[14:12];
      f7 = inst[31:25];
      a = mRegs[inst[19:15]];
      b = mRegs[inst[24:20]];
      npc = pc + 4;
      wr = 1'b0;
      val = '0;
      illegal = 1'b0;
      cond = 1'b0;
      case (inst[6:0])
        7'b0110111: begin
          wr = 1'b1;
          val = {inst[31:12], 12'b0};
        end
        7'b0010111: begin
          wr = 1'b1;
          val = pc + {inst[31:12], 12'b0};
        end
        7'b1101111: begin
          wr = 1'b1;
          val = pc + 4;
          npc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        7'b1100111: begin
          wr = 1'b1;
          illegal = f3 != 0;
          val = pc + 4;
          npc = (a + {{20{inst[31]}}, inst[31:20]}) & ~32'd1;
        end
        7'b1100011: begin
          case (f3)
            3'd0: cond = a == b;
            3'd1: cond = a != b;
            3'd4: cond = $signed(a) < $signed(b);
            3'd5: cond = $signed(a) >= $signed(b);
            3'd6: cond = a < b;
            3'd7: cond = a >= b;
            default: illegal = 1'b1;
          endcase
          if (cond) begin
            npc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end
        7'b0000011: begin
          wr = 1'b1;
          illegal = f3 == 3 || f3 >= 6;
          val = loadModel(a + {{20{inst[31]}}, inst[31:20]}, f3);
        end
        7'b0100011: begin
          illegal = f3 >= 3;
          if (!illegal) begin
            storeModel(a + {{20{inst[31]}}, inst[31:25], inst[11:7]}, f3, b);
          end
        end
        7'b0010011: begin
          wr = 1'b1;
          illegal = (f3 == 1 && f7 != 0) || (f3 == 5 && f7 != 0 && f7 != 7'h20);
          val = aluModel(f3, f3 == 5 && f7[5], a, {{20{inst[31]}}, inst[31:20]});
        end
        7'b0110011: begin
          wr = 1'b1;
          illegal = !(f7 == 0 || (f7 == 7'h20 && (f3 == 0 || f3 == 5)));
          val = aluModel(f3, f7[5], a, b);
        end
        default: begin
          if (inst == EBREAK) begin
            mHalted = 1'b1;
            done = 1'b1;
          end else begin
            illegal = 1'b1;
          end
        end
      endcase
      if (illegal) begin
        mTrapped = 1'b1;
        done = 1'b1;
      end else if (!done) begin
        if (wr && inst[11:7] != 0) begin
          mRegs[inst[11:7]] = val;
        end
        mRetired++;
        pc = npc;
      end
      steps++;
    end
  endtask

  task automatic applyReset();
    @(negedge clk);
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic loadProgram();
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      @(negedge clk);
      imemWe = 1'b1;
      imemAddr = i[$clog2(`IMEM_WORDS)-1:0];
      imemWdata = prog[i];
    end
    @(negedge clk);
    imemWe = 1'b0;
  endtask

  task automatic waitForEnd(input string name);
    int cycles;
    cycles = 0;
    while (!(halted || trapped) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!(halted || trapped)) begin
      $display("%s: core neither halted nor trapped within %0d cycles", name, TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout in %s", name);
    end
  endtask

  task automatic compareRegs(input string name);
    for (int r = 1; r < 32; r++) begin
      dbgAddr = 5'(r);
      @(negedge clk);
      check($sformatf("%s x%0d", name, r), mRegs[r], dbgData);
    end
  endtask

  task automatic runTest(input string name, input int kind);
    buildProgram(kind);
    runModel();
    applyReset();
    loadProgram();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check({name, " running"}, 32'd1, running);
    waitForEnd(name);
    check({name, " halted"}, mHalted, halted);
    check({name, " trapped"}, mTrapped, trapped);
    check({name, " instRet"}, mRetired, instRet);
    check({name, " cycles"}, 32'd1, cycleCount >= instRet);
    compareRegs(name);
  endtask

  task automatic checkReset();
    applyReset();
    @(negedge clk);
    check("reset running", 32'd0, running);
    check("reset halted", 32'd0, halted);
    check("reset trapped", 32'd0, trapped);
    check("reset cycleCount", 32'd0, cycleCount);
    check("reset instRet", 32'd0, instRet);
    for (int r = 0; r < 32; r++) begin
      dbgAddr = 5'(r);
      @(negedge clk);
      check($sformatf("reset x%0d", r), 32'd0, dbgData);
    end
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    imemWe = 1'b0;
    imemAddr = '0;
    imemWdata = '0;
    dbgAddr = '0;
    void'($urandom(32'ha2b0_419b));
    checkReset();
    for (int t = 0; t < 8; t++) begin
      runTest($sformatf("alu%0d", t), 0);
    end
    for (int t = 0; t < 8; t++) begin
      runTest($sformatf("mem%0d", t), 1);
    end
    for (int t = 0; t < 8; t++) begin
      runTest($sformatf("branch%0d", t), 2);
    end
    for (int t = 0; t < 4; t++) begin
      runTest($sformatf("illegal%0d", t), 3);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
verilog/cpuPkg.sv
verilog/instMem.sv
verilog/decoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/dataMem.sv
verilog/runControl.sv
verilog/perfCounter.sv
verilog/cpu.sv
sim/cpuTb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpuTb -f files.f -o cpuSim

# the log decides pass or fail
./obj_dir/cpuSim > sim.log 2>&1 || true
cat sim.log
grep -q "Verification passed" sim.log
